// ==== tb.f ====
+incdir+.
spart_host_pkg.sv
spart_line_pkg.sv
baud_gen.sv
credit_fifo.sv
tx_unit.sv
rx_unit.sv
spart.sv
tb_spart.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0
TOP = tb_spart
FILELIST = tb.f
OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
PASS_MSG = === PASS ===

# Sources named in the file list plus the shared header
SRCS = $(shell grep -v '^+' $(FILELIST)) spart_params.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_spart.sv ====
`timescale 1ns/1ps
`include "spart_params.svh"

module tb_spart;

	localparam int TB_BAUD_DIV = 2;
	localparam int BIT_CLKS = TB_BAUD_DIV * `SPART_OVERSAMPLE;
	localparam int TIMEOUT = 4000;
	localparam int N_ROWS = 11;
	localparam int N_RAND = 8;

	// One stimulus row
	// Held rows use injected frames
	typedef struct packed {
		logic inject;
		spart_host_pkg::data_t data;
		logic stop_low;
		logic hold;
		spart_host_pkg::rx_entry_t exp_ent;
		logic drop;
	} row_t;

	localparam row_t ROWS [N_ROWS] = '{
		'{1'b0, 8'h55, 1'b0, 1'b0, '{8'h55, 1'b0}, 1'b0},
		'{1'b0, 8'hA3, 1'b0, 1'b0, '{8'hA3, 1'b0}, 1'b0},
		'{1'b1, 8'h3C, 1'b0, 1'b0, '{8'h3C, 1'b0}, 1'b0},
		// Stop bit forced low
		'{1'b1, 8'h81, 1'b1, 1'b0, '{8'h81, 1'b1}, 1'b0},
		'{1'b0, 8'h00, 1'b0, 1'b0, '{8'h00, 1'b0}, 1'b0},
		// Host holds rx credits
		// FIFO depth worth of frames is kept
		'{1'b1, 8'h11, 1'b0, 1'b1, '{8'h11, 1'b0}, 1'b0},
		'{1'b1, 8'h22, 1'b0, 1'b1, '{8'h22, 1'b0}, 1'b0},
		'{1'b1, 8'h33, 1'b1, 1'b1, '{8'h33, 1'b1}, 1'b0},
		'{1'b1, 8'h44, 1'b0, 1'b1, '{8'h44, 1'b0}, 1'b0},
		// No room left so these are lost
		'{1'b1, 8'h55, 1'b0, 1'b1, '{8'h55, 1'b0}, 1'b1},
		'{1'b1, 8'h66, 1'b0, 1'b1, '{8'h66, 1'b0}, 1'b1}
	};

	logic clk;
	logic rst;
	logic tx_valid;
	spart_host_pkg::data_t tx_data;
	logic tx_credit;
	logic txd;
	logic rxd;
	logic rx_valid;
	spart_host_pkg::rx_entry_t rx_data;
	logic rx_credit;
	logic overrun;
	logic loop_mode;
	logic inj_line;

	// Host side bookkeeping
	int tx_sent = 0;
	int tx_returned = 0;
	int rx_granted = 0;
	int rx_seen = 0;
	logic seen_drop = 1'b0;
	logic [31:0] rng = 32'd24;
	spart_host_pkg::rx_entry_t got_q [$];
	spart_host_pkg::rx_entry_t kept_q [$];
	spart_host_pkg::data_t rand_q [$];

	always #2 clk = ~clk;

	// Loopback or testbench driven line
	assign rxd = loop_mode ? txd : inj_line;

	spart #(
		.BAUD_DIV(TB_BAUD_DIV)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_credit(tx_credit),
		.txd(txd),
		.rxd(rxd),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_credit(rx_credit),
		.overrun(overrun)
	);

	////////////////////
	// Monitors
	////////////////////

	// Sample mid-cycle away from the driving edge
	always @(negedge clk) begin
		if (!rst && rx_valid) begin
			got_q.push_back(rx_data);
			rx_seen++;
		end
		if (!rst && tx_credit) begin
			tx_returned++;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic spart_host_pkg::credit_t tx_credits_left();
		return spart_host_pkg::credit_t'(`SPART_FIFO_DEPTH - tx_sent + tx_returned);
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_entry(input string name, input spart_host_pkg::rx_entry_t got,
		input spart_host_pkg::rx_entry_t exp);
		if (got !== exp) begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_credit(input string name, input spart_host_pkg::credit_t got,
		input spart_host_pkg::credit_t exp);
		if (got !== exp) begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	////////////////////
	// Host drivers
	////////////////////

	// Only sends with a credit in hand
	task automatic send_byte(input spart_host_pkg::data_t b);
		int waited;
		waited = 0;
		while (tx_sent - tx_returned >= `SPART_FIFO_DEPTH) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				$display("Timeout waiting for a transmit credit");
				abort_run();
			end
		end
		@(posedge clk);
		tx_valid <= 1'b1;
		tx_data <= b;
		tx_sent++;
		@(posedge clk);
		tx_valid <= 1'b0;
	endtask

	task automatic grant_rx();
		@(posedge clk);
		rx_credit <= 1'b1;
		rx_granted++;
		@(posedge clk);
		rx_credit <= 1'b0;
	endtask

	task automatic wait_entry(output spart_host_pkg::rx_entry_t e);
		int waited;
		waited = 0;
		while (got_q.size() == 0) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				$display("Timeout waiting for an entry on rx_data");
				abort_run();
			end
		end
		e = got_q.pop_front();
	endtask

	// Start, data LSB first, stop, then one idle bit
	task automatic inject_frame(input spart_host_pkg::data_t d, input logic stop_low);
		spart_line_pkg::frame_t f;
		f = {~stop_low, d, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			inj_line <= f[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		inj_line <= 1'b1;
		repeat (BIT_CLKS) @(posedge clk);
	endtask

	// One credit per kept entry and the order must hold
	task automatic drain_kept();
		spart_host_pkg::rx_entry_t e;
		while (kept_q.size() > 0) begin
			grant_rx();
			wait_entry(e);
			check_entry("rx_data", e, kept_q.pop_front());
		end
	endtask

	task automatic send_random(input int n);
		for (int k = 0; k < n; k++) begin
			rng = xorshift32(rng);
			rand_q.push_back(rng[7:0]);
			send_byte(rng[7:0]);
		end
	endtask

	task automatic receive_random(input int n);
		spart_host_pkg::rx_entry_t e;
		spart_host_pkg::rx_entry_t want;
		for (int k = 0; k < n; k++) begin
			grant_rx();
			wait_entry(e);
			want.data = rand_q.pop_front();
			want.frame_err = 1'b0;
			check_entry("rx_data", e, want);
		end
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial begin
		row_t row;
		spart_host_pkg::rx_entry_t e;
		clk = 1'b0;
		rst = 1'b1;
		tx_valid = 1'b0;
		tx_data = '0;
		rx_credit = 1'b0;
		inj_line = 1'b1;
		loop_mode = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		// Idle state out of reset
		@(negedge clk);
		check_flag("txd", txd, 1'b1);
		check_flag("rx_valid", rx_valid, 1'b0);
		check_flag("tx_credit", tx_credit, 1'b0);
		check_flag("overrun", overrun, 1'b0);
		for (int r = 0; r < N_ROWS; r++) begin
			row = ROWS[r];
			@(posedge clk);
			loop_mode <= !row.inject;
			if (row.inject) begin
				inject_frame(row.data, row.stop_low);
			end else begin
				send_byte(row.data);
			end
			if (!row.hold) begin
				grant_rx();
				wait_entry(e);
				check_entry("rx_data", e, row.exp_ent);
			end else begin
				if (row.drop) begin
					seen_drop = 1'b1;
				end else begin
					kept_q.push_back(row.exp_ent);
				end
				check_flag("overrun", overrun, seen_drop);
			end
		end
		drain_kept();
		// Random bytes through the loopback
		// Sender and host run together
		@(posedge clk);
		loop_mode <= 1'b1;
		fork
			send_random(N_RAND);
			receive_random(N_RAND);
		join
		repeat (BIT_CLKS) @(negedge clk);
		check_credit("tx_credits", tx_credits_left(), `SPART_FIFO_DEPTH);
		check_credit("rx_credits", spart_host_pkg::credit_t'(rx_granted - rx_seen), '0);
		check_flag("overrun", overrun, 1'b1);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== spart.sv ====
`timescale 1ns/1ps
`include "spart_params.svh"

module spart #(
	parameter int BAUD_DIV = `SPART_BAUD_DIV
) (
	input logic clk,
	input logic rst,
	input logic tx_valid,
	input spart_host_pkg::data_t tx_data,
	output logic tx_credit,
	output logic txd,
	input logic rxd,
	output logic rx_valid,
	output spart_host_pkg::rx_entry_t rx_data,
	input logic rx_credit,
	output logic overrun
);

	logic tick;
	logic buf_valid;
	spart_host_pkg::data_t buf_data;
	logic buf_credit;
	logic ent_valid;
	spart_host_pkg::rx_entry_t ent_data;
	logic ent_credit;

	////////////////////
	// Shared timebase
	////////////////////

	baud_gen #(
		.BAUD_DIV(BAUD_DIV)
	) baud_gen_i (
		.clk(clk),
		.rst(rst),
		.tick(tick)
	);

	////////////////////
	// Transmit path
	////////////////////

	// One credit toward tx_unit, its standby slot
	credit_fifo #(
		.payload_t(spart_host_pkg::data_t),
		.DEPTH(`SPART_FIFO_DEPTH),
		.INIT_CREDITS(1)
	) tx_fifo_i (
		.clk(clk),
		.rst(rst),
		.in_valid(tx_valid),
		.in_data(tx_data),
		.in_credit(tx_credit),
		.out_valid(buf_valid),
		.out_data(buf_data),
		.out_credit(buf_credit)
	);

	tx_unit tx_unit_i (
		.clk(clk),
		.rst(rst),
		.tick(tick),
		.buf_valid(buf_valid),
		.buf_data(buf_data),
		.buf_credit(buf_credit),
		.txd(txd)
	);

	////////////////////
	// Receive path
	////////////////////

	rx_unit rx_unit_i (
		.clk(clk),
		.rst(rst),
		.tick(tick),
		.rxd(rxd),
		.ent_credit(ent_credit),
		.ent_valid(ent_valid),
		.ent_data(ent_data),
		.overrun(overrun)
	);

	// Host grants every credit, none at reset
	credit_fifo #(
		.payload_t(spart_host_pkg::rx_entry_t),
		.DEPTH(`SPART_FIFO_DEPTH),
		.INIT_CREDITS(0)
	) rx_fifo_i (
		.clk(clk),
		.rst(rst),
		.in_valid(ent_valid),
		.in_data(ent_data),
		.in_credit(ent_credit),
		.out_valid(rx_valid),
		.out_data(rx_data),
		.out_credit(rx_credit)
	);

endmodule

// ==== rx_unit.sv ====
`timescale 1ns/1ps
`include "spart_params.svh"

module rx_unit (
	input logic clk,
	input logic rst,
	input logic tick,
	input logic rxd,
	input logic ent_credit,
	output logic ent_valid,
	output spart_host_pkg::rx_entry_t ent_data,
	output logic overrun
);

	localparam spart_line_pkg::tick_cnt_t LAST_TICK =
		spart_line_pkg::tick_cnt_t'(`SPART_OVERSAMPLE - 1);
	localparam spart_line_pkg::tick_cnt_t MID_TICK =
		spart_line_pkg::tick_cnt_t'(`SPART_OVERSAMPLE / 2 - 1);
	localparam spart_line_pkg::bit_cnt_t LAST_DATA = spart_line_pkg::bit_cnt_t'(7);

	spart_line_pkg::rx_state_t state;
	spart_line_pkg::rx_state_t state_nxt;
	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;
	logic fall;
	logic mid;
	logic smp;
	logic done;
	logic take;
	spart_line_pkg::tick_cnt_t tick_cnt;
	spart_line_pkg::bit_cnt_t bit_cnt;
	spart_host_pkg::data_t rx_shift;
	spart_host_pkg::credit_t credits;

	////////////////////
	// Line input
	////////////////////

	// Two flop sync, then one more for edge detect
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_comb begin
		fall = rxd_prev && !rxd_sync;
		// Half a bit into start
		mid = tick && (tick_cnt == MID_TICK);
		// One full bit later, mid of the next bit
		smp = tick && (tick_cnt == LAST_TICK);
		done = (state == spart_line_pkg::RX_STOP) && smp;
		take = done && (credits != '0);
	end

	////////////////////
	// Frame FSM
	////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			spart_line_pkg::RX_IDLE: begin
				if (fall) begin
					state_nxt = spart_line_pkg::RX_START;
				end
			end
			spart_line_pkg::RX_START: begin
				// High at mid-bit means a glitch
				if (mid) begin
					state_nxt = rxd_sync ? spart_line_pkg::RX_IDLE : spart_line_pkg::RX_DATA;
				end
			end
			spart_line_pkg::RX_DATA: begin
				if (smp && (bit_cnt == LAST_DATA)) begin
					state_nxt = spart_line_pkg::RX_STOP;
				end
			end
			spart_line_pkg::RX_STOP: begin
				if (smp) begin
					state_nxt = spart_line_pkg::RX_IDLE;
				end
			end
			default: state_nxt = spart_line_pkg::RX_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= spart_line_pkg::RX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			credits <= spart_host_pkg::credit_t'(`SPART_FIFO_DEPTH);
			ent_valid <= 1'b0;
			overrun <= 1'b0;
		end else begin
			state <= state_nxt;
			// Tick count restarts at the confirmed start mid-point
			if (state == spart_line_pkg::RX_IDLE) begin
				tick_cnt <= '0;
			end else if (tick) begin
				if ((state == spart_line_pkg::RX_START) && mid) begin
					tick_cnt <= '0;
				end else begin
					tick_cnt <= smp ? '0 : tick_cnt + 1'b1;
				end
			end
			if (state == spart_line_pkg::RX_START) begin
				bit_cnt <= '0;
			end else if ((state == spart_line_pkg::RX_DATA) && smp) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			// Push only with a credit in hand
			ent_valid <= take;
			// Sticky until reset
			if (done && !take) begin
				overrun <= 1'b1;
			end
			case ({take, ent_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	////////////////////
	// Payload
	////////////////////

	// LSB arrives first, shift in from the top
	always_ff @(posedge clk) begin
		if ((state == spart_line_pkg::RX_DATA) && smp) begin
			rx_shift <= {rxd_sync, rx_shift[7:1]};
		end
		if (done) begin
			ent_data.data <= rx_shift;
			ent_data.frame_err <= !rxd_sync;
		end
	end

endmodule

// ==== tx_unit.sv ====
`timescale 1ns/1ps
`include "spart_params.svh"

module tx_unit (
	input logic clk,
	input logic rst,
	input logic tick,
	input logic buf_valid,
	input spart_host_pkg::data_t buf_data,
	output logic buf_credit,
	output logic txd
);

	localparam spart_line_pkg::tick_cnt_t LAST_TICK =
		spart_line_pkg::tick_cnt_t'(`SPART_OVERSAMPLE - 1);
	// Stop bit is index 9
	localparam spart_line_pkg::bit_cnt_t LAST_BIT = spart_line_pkg::bit_cnt_t'(9);

	spart_line_pkg::tx_state_t state;
	spart_line_pkg::tx_state_t state_nxt;
	spart_host_pkg::data_t tx_buf;
	logic buf_full;
	spart_line_pkg::frame_t shift_reg;
	spart_line_pkg::tick_cnt_t tick_cnt;
	spart_line_pkg::bit_cnt_t bit_cnt;
	logic bit_end;
	logic frame_end;
	logic load_frame;
	logic shift;

	////////////////////
	// Control
	////////////////////

	always_comb begin
		// Current bit has run its full tick count
		bit_end = (state == spart_line_pkg::TX_SEND) && tick && (tick_cnt == LAST_TICK);
		frame_end = bit_end && (bit_cnt == LAST_BIT);
		// From BUF on a tick, or straight after a frame when standby is full
		load_frame = ((state == spart_line_pkg::TX_BUF) && tick) || (frame_end && buf_full);
		shift = bit_end && !frame_end;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			spart_line_pkg::TX_IDLE: begin
				// Byte may have landed on the last edge of a frame
				if (buf_valid || buf_full) begin
					state_nxt = spart_line_pkg::TX_BUF;
				end
			end
			spart_line_pkg::TX_BUF: begin
				if (tick) begin
					state_nxt = spart_line_pkg::TX_SEND;
				end
			end
			spart_line_pkg::TX_SEND: begin
				// Back to back frames stay in SEND
				if (frame_end && !buf_full) begin
					state_nxt = spart_line_pkg::TX_IDLE;
				end
			end
			default: state_nxt = spart_line_pkg::TX_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= spart_line_pkg::TX_IDLE;
			buf_full <= 1'b0;
			buf_credit <= 1'b0;
			tick_cnt <= '0;
			bit_cnt <= '0;
			shift_reg <= '1;
		end else begin
			state <= state_nxt;
			// Standby slot, credit keeps it from overfilling
			if (buf_valid) begin
				buf_full <= 1'b1;
			end else if (load_frame) begin
				buf_full <= 1'b0;
			end
			// Slot freed as the byte enters the shifter
			buf_credit <= load_frame;
			// Tick and bit counters
			if (load_frame) begin
				tick_cnt <= '0;
				bit_cnt <= '0;
			end else if ((state == spart_line_pkg::TX_SEND) && tick) begin
				tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
				if (shift) begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
			// Ones fill from the top, line idles high
			if (load_frame) begin
				shift_reg <= {1'b1, tx_buf, 1'b0};
			end else if (shift) begin
				shift_reg <= {1'b1, shift_reg[9:1]};
			end
		end
	end

	// Standby byte
	always_ff @(posedge clk) begin
		if (buf_valid) begin
			tx_buf <= buf_data;
		end
	end

	assign txd = shift_reg[0];

endmodule

// ==== credit_fifo.sv ====
`timescale 1ns/1ps
`include "spart_params.svh"

module credit_fifo #(
	parameter type payload_t = spart_host_pkg::data_t,
	parameter int DEPTH = `SPART_FIFO_DEPTH,
	parameter int INIT_CREDITS = 0
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input payload_t in_data,
	output logic in_credit,
	output logic out_valid,
	output payload_t out_data,
	input logic out_credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	spart_host_pkg::credit_t credits;
	logic pop;

	// Pop needs a stored entry and a downstream credit
	assign pop = (count != '0) && (credits != '0);

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// Output register, valid is qualified separately
	always_ff @(posedge clk) begin
		if (pop) begin
			out_data <= mem[rd_ptr];
		end
	end

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= spart_host_pkg::credit_t'(INIT_CREDITS);
			out_valid <= 1'b0;
			in_credit <= 1'b0;
		end else begin
			// Circular pointers
			if (in_valid) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			// Occupancy
			case ({in_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Spend on pop, refill on each downstream pulse
			case ({pop, out_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			// Freed slot goes back upstream one cycle after the pop
			out_valid <= pop;
			in_credit <= pop;
		end
	end

endmodule

// ==== baud_gen.sv ====
`timescale 1ns/1ps
`include "spart_params.svh"

module baud_gen #(
	parameter int BAUD_DIV = `SPART_BAUD_DIV
) (
	input logic clk,
	input logic rst,
	output logic tick
);

	// Counter must hold BAUD_DIV-1, at least one bit
	localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(BAUD_DIV - 1);

	logic [CNT_W-1:0] div_cnt;
	logic wrap;

	assign wrap = (div_cnt == LAST);

	////////////////////
	// Divider
	////////////////////

	// Free running, wraps every BAUD_DIV cycles
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			div_cnt <= '0;
		end else if (wrap) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// One-cycle tick per wrap, shared by tx and rx
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tick <= 1'b0;
		end else begin
			tick <= wrap;
		end
	end

endmodule

// ==== spart_line_pkg.sv ====
`include "spart_params.svh"

package spart_line_pkg;

	////////////////////
	// Frame on the wire
	////////////////////

	// Stop, eight data bits, start, LSB leaves first
	typedef logic [9:0] frame_t;

	////////////////////
	// State machines
	////////////////////

	// Transmit side
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_BUF,
		TX_SEND
	} tx_state_t;

	// Receive side
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// Tick within one bit time
	typedef logic [$clog2(`SPART_OVERSAMPLE) - 1:0] tick_cnt_t;

	// Bit index within one frame
	typedef logic [3:0] bit_cnt_t;

endpackage

// ==== spart_host_pkg.sv ====
`include "spart_params.svh"

package spart_host_pkg;

	////////////////////
	// Host payloads
	////////////////////

	// One data byte
	typedef logic [7:0] data_t;

	// Received byte plus stop bit check
	typedef struct packed {
		data_t data;
		logic frame_err;
	} rx_entry_t;

	////////////////////
	// Flow control
	////////////////////

	// Must reach SPART_FIFO_DEPTH
	typedef logic [$clog2(`SPART_FIFO_DEPTH + 1) - 1:0] credit_t;

endpackage

// ==== spart_params.svh ====
`ifndef SPART_PARAMS_SVH
`define SPART_PARAMS_SVH

////////////////////
// Serial timebase
////////////////////

// clk cycles per oversampling tick
`define SPART_BAUD_DIV 16

// Oversampling ticks per bit on the line
`define SPART_OVERSAMPLE 16

////////////////////
// Buffering
////////////////////

// Entries in each FIFO
`define SPART_FIFO_DEPTH 4

`endif
